// ==== rv_core.f ====
+incdir+logic
logic/rv_pkg.sv
logic/rv_fetch_stage.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_lsu.sv
logic/rv_execute_stage.sv
logic/rv_core.sv
tests/tb_rv_data_mem.sv
tests/tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tb_rv_core.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_rv_core;

    localparam int CLK_PERIOD   = 100;
    localparam int TOTAL_INSTRS = 140;   // Summed over all test programs

    logic                clk;
    logic                reset;
    logic [`RV_ILEN-1:0] instr;
    logic [`RV_XLEN-1:0] pc;
    rv_pkg::rv_bus_req_t bus_req;
    logic                bus_valid, bus_ack;
    logic [`RV_XLEN-1:0] bus_rdata;

    logic [31:0]         imem [0:255];
    logic [`RV_XLEN-1:0] exp_addr[$];
    logic [`RV_XLEN-1:0] exp_data[$];
    logic [31:0]         lcg_state = 32'h4a94_4ed8;
    int                  prog_len, st_off, errors, checks;

    assign instr = imem[pc[9:2]];   // Combinational instruction memory

    rv_core DUT (
        .clk         (clk),
        .reset       (reset),
        .instr_i     (instr),
        .pc_o        (pc),
        .bus_req_o   (bus_req),
        .bus_valid_o (bus_valid),
        .bus_ack_i   (bus_ack),
        .bus_rdata_i (bus_rdata)
    );

    tb_rv_data_mem u_mem (
        .clk     (clk),
        .req_i   (bus_req),
        .valid_i (bus_valid),
        .ack_o   (bus_ack),
        .rdata_o (bus_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [63:0] sext12(logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    // Instruction encoders
    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    task automatic check(string name, logic [63:0] expected, logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic emit(logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    // SD rs to the next slot above x31 and note the expected write
    task automatic store_expect(logic [4:0] rs, logic [63:0] value);
        emit(enc_s(st_off[11:0], rs, 5'd31));
        exp_addr.push_back(64'h1000 + st_off);
        exp_data.push_back(value);
        st_off += 8;
    endtask

    // LUI plus ADDI, returns the value that RV64 puts in rd
    task automatic load_const(logic [4:0] rd, logic [31:0] v, output logic [63:0] value);
        logic [19:0] hi;
        hi = v[31:12] + {19'd0, v[11]};
        emit({hi, rd, `RV_OP_LUI});
        emit(enc_i(v[11:0], rd, 3'b000, rd, `RV_OP_IMM));
        value = {{32{hi[19]}}, hi, 12'd0} + sext12(v[11:0]);
    endtask

    task automatic new_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = `RV_NOP;
        end
        prog_len = 0;
        st_off   = 0;
        exp_addr.delete();
        exp_data.delete();
        emit({20'h00001, 5'd31, `RV_OP_LUI});   // x31 = 0x1000, store base
    endtask

    task automatic apply_reset();
        reset = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #5;
            check("pc_o in reset", `RV_RESET_PC, pc);
            check("bus_valid_o in reset", 64'd0, {63'd0, bus_valid});
        end
        reset = 1'b1;
    endtask

    // Runs the program and compares the logged writes with the expected ones
    task automatic run_program(string name, int pc_steps);
        int cycles;
        emit(enc_j(21'd0, 5'd0));   // Park on a self-loop
        u_mem.wr_addr_q.delete();
        u_mem.wr_data_q.delete();
        apply_reset();
        for (int i = 1; i <= pc_steps; i++) begin
            @(posedge clk);
            #5;
            check("pc_o step", 64'(4 * i), pc);
        end
        cycles = 0;
        while (u_mem.wr_addr_q.size() < exp_addr.size() && cycles < prog_len * 20) begin
            @(posedge clk);
            cycles++;
        end
        repeat (10) @(posedge clk);   // Catch any extra write
        #5;
        if (u_mem.wr_addr_q.size() != exp_addr.size()) begin
            errors++;
            $display("%s: saw %0d bus writes where %0d were expected", name,
                     u_mem.wr_addr_q.size(), exp_addr.size());
        end
        for (int i = 0; i < exp_addr.size() && i < u_mem.wr_addr_q.size(); i++) begin
            check({name, " bus_req_o.addr"}, exp_addr[i], u_mem.wr_addr_q[i]);
            check({name, " bus_req_o.wdata"}, exp_data[i], u_mem.wr_data_q[i]);
        end
    endtask

    task automatic test_reset_and_pc();
        new_program();
        for (int i = 0; i < 8; i++) begin
            emit(enc_i(12'd1, 5'd1, 3'b000, 5'd1, `RV_OP_IMM));
        end
        store_expect(5'd1, 64'd8);
        run_program("reset", 6);
    endtask

    task automatic alu_case(logic [31:0] word, logic [63:0] expected);
        emit(word);
        store_expect(5'd5, expected);
    endtask

    task automatic test_alu();
        logic [63:0] a, b;
        logic [31:0] r;
        logic [11:0] imm;
        logic [5:0]  sh, shb;
        new_program();
        load_const(5'd1, next_rand(), a);
        load_const(5'd2, next_rand(), b);
        r   = next_rand();
        imm = r[27:16];
        r   = next_rand();
        sh  = r[21:16];
        shb = b[5:0];
        alu_case(enc_i(imm, 5'd1, 3'b000, 5'd5, `RV_OP_IMM), a + sext12(imm));
        alu_case(enc_i(imm, 5'd1, 3'b010, 5'd5, `RV_OP_IMM),
                 {63'd0, $signed(a) < $signed(sext12(imm))});
        alu_case(enc_i(imm, 5'd1, 3'b011, 5'd5, `RV_OP_IMM), {63'd0, a < sext12(imm)});
        alu_case(enc_i(imm, 5'd1, 3'b100, 5'd5, `RV_OP_IMM), a ^ sext12(imm));
        alu_case(enc_i(imm, 5'd1, 3'b110, 5'd5, `RV_OP_IMM), a | sext12(imm));
        alu_case(enc_i(imm, 5'd1, 3'b111, 5'd5, `RV_OP_IMM), a & sext12(imm));
        alu_case(enc_i({6'b000000, sh}, 5'd1, 3'b001, 5'd5, `RV_OP_IMM), a << sh);
        alu_case(enc_i({6'b000000, sh}, 5'd1, 3'b101, 5'd5, `RV_OP_IMM), a >> sh);
        alu_case(enc_i({6'b010000, sh}, 5'd1, 3'b101, 5'd5, `RV_OP_IMM), $signed(a) >>> sh);
        alu_case(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5), a + b);
        alu_case(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd5), a - b);
        alu_case(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd5), a << shb);
        alu_case(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd5), {63'd0, $signed(a) < $signed(b)});
        alu_case(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd5), {63'd0, a < b});
        alu_case(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd5), a ^ b);
        alu_case(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd5), a >> shb);
        alu_case(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd5), $signed(a) >>> shb);
        alu_case(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd5), a | b);
        alu_case(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd5), a & b);
        emit(enc_i(12'd5, 5'd1, 3'b000, 5'd0, `RV_OP_IMM));   // x0 stays zero
        store_expect(5'd0, 64'd0);
        run_program("alu", 0);
    endtask

    task automatic test_upper();
        logic [31:0] r;
        logic [63:0] u;
        new_program();
        for (int i = 0; i < 3; i++) begin
            r = next_rand();
            u = {{32{r[31]}}, r[31:12], 12'd0};
            emit({r[31:12], 5'd5, `RV_OP_LUI});
            store_expect(5'd5, u);
            emit({r[31:12], 5'd6, `RV_OP_AUIPC});
            store_expect(5'd6, u + 64'(4 * (prog_len - 1)));
        end
        run_program("upper", 0);
    endtask

    // Branch over one ADDI; taken cases bump x7, which must stay zero
    task automatic branch_case(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2, bit taken);
        emit(enc_b(13'd8, rs2, rs1, f3));
        emit(enc_i(12'd1, taken ? 5'd7 : 5'd8, 3'b000, taken ? 5'd7 : 5'd8, `RV_OP_IMM));
    endtask

    task automatic test_control();
        logic [63:0] v;
        int          p;
        new_program();
        load_const(5'd1, 32'd5, v);
        load_const(5'd2, 32'hffff_fffd, v);   // -3
        branch_case(3'b000, 5'd1, 5'd1, 1);
        branch_case(3'b000, 5'd1, 5'd2, 0);
        branch_case(3'b001, 5'd1, 5'd2, 1);
        branch_case(3'b001, 5'd1, 5'd1, 0);
        branch_case(3'b100, 5'd2, 5'd1, 1);
        branch_case(3'b100, 5'd1, 5'd2, 0);
        branch_case(3'b101, 5'd1, 5'd2, 1);
        branch_case(3'b101, 5'd2, 5'd1, 0);
        branch_case(3'b110, 5'd1, 5'd2, 1);
        branch_case(3'b110, 5'd2, 5'd1, 0);
        branch_case(3'b111, 5'd2, 5'd1, 1);
        branch_case(3'b111, 5'd1, 5'd2, 0);
        p = 4 * prog_len;
        emit(enc_j(21'd12, 5'd10));
        emit(enc_i(12'd1, 5'd7, 3'b000, 5'd7, `RV_OP_IMM));
        emit(enc_i(12'd1, 5'd7, 3'b000, 5'd7, `RV_OP_IMM));
        store_expect(5'd10, 64'(p + 4));
        p = 4 * prog_len;
        emit({20'd0, 5'd11, `RV_OP_AUIPC});
        emit(enc_i(12'd13, 5'd11, 3'b000, 5'd12, `RV_OP_JALR));   // Bit 0 cleared
        emit(enc_i(12'd1, 5'd7, 3'b000, 5'd7, `RV_OP_IMM));
        emit({20'd0, 5'd13, `RV_OP_AUIPC});   // Records the target pc
        store_expect(5'd12, 64'(p + 8));
        store_expect(5'd13, 64'(p + 12));
        store_expect(5'd7, 64'd0);
        store_expect(5'd8, 64'd6);
        run_program("control", 0);
    endtask

    task automatic test_memory();
        logic [63:0] v;
        new_program();
        emit({20'h00002, 5'd30, `RV_OP_LUI});   // x30 = 0x2000
        for (int k = 0; k < 4; k++) begin
            load_const(5'd5, next_rand(), v);
            emit(enc_s(12'(8 * k), 5'd5, 5'd30));
            exp_addr.push_back(64'h2000 + 8 * k);
            exp_data.push_back(v);
            emit(enc_i(12'(8 * k), 5'd30, 3'b011, 5'd6, `RV_OP_LOAD));
            emit(enc_i(12'd1, 5'd6, 3'b000, 5'd6, `RV_OP_IMM));
            emit(enc_s(12'(8 * k + 64), 5'd6, 5'd30));
            exp_addr.push_back(64'h2040 + 8 * k);
            exp_data.push_back(v + 64'd1);
        end
        run_program("memory", 0);
    endtask

    initial begin
        #(TOTAL_INSTRS * 20 * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        reset  = 1'b0;
        errors = 0;
        checks = 0;
        test_reset_and_pc();
        test_alu();
        test_upper();
        test_control();
        test_memory();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== tests/tb_rv_data_mem.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_rv_data_mem (
    input  logic                clk,
    input  rv_pkg::rv_bus_req_t req_i,
    input  logic                valid_i,
    output logic                ack_o,
    output logic [`RV_XLEN-1:0] rdata_o
);

    logic [`RV_XLEN-1:0] mem [logic [`RV_XLEN-1:0]];
    logic [`RV_XLEN-1:0] wr_addr_q[$];   // Write log, read by the testbench
    logic [`RV_XLEN-1:0] wr_data_q[$];
    logic [31:0]         lcg_state = 32'h4a94_4ed8;
    int                  pending = -1;
    logic [31:0]         r;

    function automatic logic [31:0] lcg_step(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Unwritten words read back a pattern of the full address
    function automatic logic [`RV_XLEN-1:0] fill(logic [`RV_XLEN-1:0] a);
        return a ^ {a[31:0], a[63:32]} ^ 64'h5a5a_c3c3_0f0f_9696;
    endfunction

    initial begin
        ack_o   = 1'b0;
        rdata_o = '0;
        forever begin
            @(posedge clk);
            #2;
            if (valid_i && !ack_o) begin
                if (pending < 0) begin
                    lcg_state = lcg_step(lcg_state);
                    r         = lcg_state >> 16;
                    pending   = int'(r[1:0]);   // 0 to 3 cycles of back-pressure
                end
                if (pending == 0) begin
                    if (req_i.we) begin
                        mem[req_i.addr] = req_i.wdata;
                        wr_addr_q.push_back(req_i.addr);
                        wr_data_q.push_back(req_i.wdata);
                    end
                    rdata_o = mem.exists(req_i.addr) ? mem[req_i.addr] : fill(req_i.addr);
                    ack_o   = 1'b1;
                    pending = -1;
                end else begin
                    pending--;
                end
            end else if (!valid_i && ack_o) begin
                ack_o = 1'b0;   // Close the handshake
            end
        end
    end

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core (
    input  logic                clk,
    input  logic                reset,
    input  logic [`RV_ILEN-1:0] instr_i,
    output logic [`RV_XLEN-1:0] pc_o,
    output rv_pkg::rv_bus_req_t bus_req_o,
    output logic                bus_valid_o,
    input  logic                bus_ack_i,
    input  logic [`RV_XLEN-1:0] bus_rdata_i
);

    rv_pkg::rv_instr_u   fetch_word;
    logic [`RV_XLEN-1:0] fetch_pc, target_pc;
    logic                stall, redirect;

    rv_fetch_stage u_fetch (
        .clk          (clk),
        .reset        (reset),
        .instr_i      (instr_i),
        .stall_i      (stall),
        .redirect_i   (redirect),
        .target_pc_i  (target_pc),
        .pc_o         (pc_o),
        .fetch_word_o (fetch_word),
        .fetch_pc_o   (fetch_pc)
    );

    rv_execute_stage u_execute (
        .clk          (clk),
        .reset        (reset),
        .fetch_word_i (fetch_word),
        .fetch_pc_i   (fetch_pc),
        .stall_o      (stall),
        .redirect_o   (redirect),
        .target_pc_o  (target_pc),
        .bus_req_o    (bus_req_o),
        .bus_valid_o  (bus_valid_o),
        .bus_ack_i    (bus_ack_i),
        .bus_rdata_i  (bus_rdata_i)
    );

endmodule

// ==== logic/rv_execute_stage.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  rv_pkg::rv_instr_u   fetch_word_i,
    input  logic [`RV_XLEN-1:0] fetch_pc_i,
    output logic                stall_o,
    output logic                redirect_o,
    output logic [`RV_XLEN-1:0] target_pc_o,
    output rv_pkg::rv_bus_req_t bus_req_o,
    output logic                bus_valid_o,
    input  logic                bus_ack_i,
    input  logic [`RV_XLEN-1:0] bus_rdata_i
);

    rv_pkg::rv_decoded_t dec;
    logic [`RV_XLEN-1:0] rs1_data, rs2_data;
    logic [`RV_XLEN-1:0] op_a, op_b, alu_result;
    logic [`RV_XLEN-1:0] load_data, link_pc, wb_data;
    logic                branch_taken, lsu_busy, wb_en;

    rv_decoder u_decoder (
        .instr_i (fetch_word_i),
        .dec_o   (dec)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .reset      (reset),
        .rs1_i      (dec.rs1),
        .rs2_i      (dec.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_en),
        .rd_i       (dec.rd),
        .rd_data_i  (wb_data)
    );

    assign op_a = dec.a_pc ? fetch_pc_i : rs1_data;
    assign op_b = dec.b_imm ? dec.imm : rs2_data;   // Branches compare rs1 with rs2

    rv_alu u_alu (
        .op_i           (dec.alu_op),
        .a_i            (op_a),
        .b_i            (op_b),
        .funct3_i       (dec.funct3),
        .result_o       (alu_result),
        .branch_taken_o (branch_taken)
    );

    rv_lsu u_lsu (
        .clk           (clk),
        .reset         (reset),
        .start_load_i  (dec.is_load),
        .start_store_i (dec.is_store),
        .addr_i        (alu_result),
        .wdata_i       (rs2_data),
        .busy_o        (lsu_busy),
        .load_data_o   (load_data),
        .bus_req_o     (bus_req_o),
        .bus_valid_o   (bus_valid_o),
        .bus_ack_i     (bus_ack_i),
        .bus_rdata_i   (bus_rdata_i)
    );

    assign link_pc = fetch_pc_i + 'd4;

    always_comb begin
        if (dec.is_load) begin
            wb_data = load_data;
        end else if (dec.is_jal || dec.is_jalr) begin
            wb_data = link_pc;
        end else begin
            wb_data = alu_result;
        end
    end

    assign wb_en   = dec.wr_rd && !lsu_busy;   // Loads write in the LSU done cycle
    assign stall_o = lsu_busy;

    assign redirect_o  = dec.is_jal || dec.is_jalr || (dec.is_branch && branch_taken);
    assign target_pc_o = dec.is_jalr ? {alu_result[`RV_XLEN-1:1], 1'b0} : fetch_pc_i + dec.imm;

    a_decoded: assert property (@(posedge clk) disable iff (!reset) !dec.illegal)
        else $warning("Undecoded instruction %h at pc %h", fetch_word_i, fetch_pc_i);

endmodule

// ==== logic/rv_lsu.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_lsu (
    input  logic                clk,
    input  logic                reset,
    input  logic                start_load_i,
    input  logic                start_store_i,
    input  logic [`RV_XLEN-1:0] addr_i,
    input  logic [`RV_XLEN-1:0] wdata_i,
    output logic                busy_o,
    output logic [`RV_XLEN-1:0] load_data_o,
    output rv_pkg::rv_bus_req_t bus_req_o,
    output logic                bus_valid_o,
    input  logic                bus_ack_i,
    input  logic [`RV_XLEN-1:0] bus_rdata_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,        // req high, waiting for ack
        S_WAIT_LOW,   // req dropped, waiting for ack to fall
        S_DONE        // one cycle to retire the instruction
    } state_e;

    state_e state;
    logic   start;

    assign start = start_load_i || start_store_i;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:     if (start) state <= S_REQ;
                S_REQ:      if (bus_ack_i) state <= S_WAIT_LOW;
                S_WAIT_LOW: if (!bus_ack_i) state <= S_DONE;
                default:    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            bus_req_o.addr  <= addr_i;
            bus_req_o.wdata <= wdata_i;
            bus_req_o.we    <= start_store_i;
        end
        if (state == S_REQ && bus_ack_i) begin
            load_data_o <= bus_rdata_i;   // Data is valid together with ack
        end
    end

    assign bus_valid_o = state == S_REQ;
    assign busy_o      = (state == S_IDLE && start) || state == S_REQ || state == S_WAIT_LOW;

    a_req_stable: assert property (@(posedge clk) disable iff (!reset)
        bus_valid_o |=> !bus_valid_o || $stable(bus_req_o));

    // Ack must already be low at the edge that launches req
    a_req_after_ack_low: assert property (@(posedge clk) disable iff (!reset)
        $rose(bus_valid_o) |-> !$past(bus_ack_i));

    // The pipeline may move on only once the slave has closed the handshake
    a_busy_until_ack_low: assert property (@(posedge clk) disable iff (!reset)
        $fell(busy_o) |-> !bus_ack_i);

endmodule

// ==== logic/rv_alu.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_alu (
    input  rv_pkg::rv_alu_op_e  op_i,
    input  logic [`RV_XLEN-1:0] a_i,
    input  logic [`RV_XLEN-1:0] b_i,
    input  logic [2:0]          funct3_i,
    output logic [`RV_XLEN-1:0] result_o,
    output logic                branch_taken_o
);

    logic [5:0] shamt;
    logic       eq, lt, ltu;

    assign shamt = b_i[5:0];
    assign eq    = a_i == b_i;
    assign lt    = $signed(a_i) < $signed(b_i);
    assign ltu   = a_i < b_i;

    always_comb begin
        case (op_i)
            rv_pkg::ALU_ADD:  result_o = a_i + b_i;
            rv_pkg::ALU_SUB:  result_o = a_i - b_i;
            rv_pkg::ALU_SLL:  result_o = a_i << shamt;
            rv_pkg::ALU_SLT:  result_o = {{(`RV_XLEN-1){1'b0}}, lt};
            rv_pkg::ALU_SLTU: result_o = {{(`RV_XLEN-1){1'b0}}, ltu};
            rv_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            rv_pkg::ALU_SRL:  result_o = a_i >> shamt;
            rv_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;
            rv_pkg::ALU_OR:   result_o = a_i | b_i;
            default:          result_o = a_i & b_i;
        endcase
    end

    // Branch condition from funct3
    always_comb begin
        case (funct3_i)
            3'b000:  branch_taken_o = eq;    // BEQ
            3'b001:  branch_taken_o = !eq;   // BNE
            3'b100:  branch_taken_o = lt;
            3'b101:  branch_taken_o = !lt;
            3'b110:  branch_taken_o = ltu;
            3'b111:  branch_taken_o = !ltu;
            default: branch_taken_o = 1'b0;
        endcase
    end

endmodule

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_regfile (
    input  logic                clk,
    input  logic                reset,
    input  logic [4:0]          rs1_i,
    input  logic [4:0]          rs2_i,
    output logic [`RV_XLEN-1:0] rs1_data_o,
    output logic [`RV_XLEN-1:0] rs2_data_o,
    input  logic                we_i,
    input  logic [4:0]          rd_i,
    input  logic [`RV_XLEN-1:0] rd_data_i
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != 5'd0) begin   // x0 never written, so it reads zero
            regs[rd_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

endmodule

// ==== logic/rv_decoder.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_decoder (
    input  rv_pkg::rv_instr_u   instr_i,
    output rv_pkg::rv_decoded_t dec_o
);

    logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    rv_pkg::rv_alu_op_e  base_op;

    // Immediates per format, sign-extended to XLEN
    assign imm_i = {{(`RV_XLEN-12){instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
    assign imm_s = {{(`RV_XLEN-12){instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5,
                    instr_i.s.imm_4_0};
    assign imm_b = {{(`RV_XLEN-13){instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                    instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
    assign imm_u = {{(`RV_XLEN-32){instr_i.u.imm_31_12[19]}}, instr_i.u.imm_31_12, 12'b0};
    assign imm_j = {{(`RV_XLEN-21){instr_i.j.imm_20}}, instr_i.j.imm_20, instr_i.j.imm_19_12,
                    instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};

    // funct3 to ALU op, shared by OP and OP-IMM
    always_comb begin
        case (instr_i.r.funct3)
            3'b000:  base_op = rv_pkg::ALU_ADD;
            3'b001:  base_op = rv_pkg::ALU_SLL;
            3'b010:  base_op = rv_pkg::ALU_SLT;
            3'b011:  base_op = rv_pkg::ALU_SLTU;
            3'b100:  base_op = rv_pkg::ALU_XOR;
            3'b101:  base_op = rv_pkg::ALU_SRL;
            3'b110:  base_op = rv_pkg::ALU_OR;
            default: base_op = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        dec_o        = '0;
        dec_o.rd     = instr_i.r.rd;
        dec_o.rs1    = instr_i.r.rs1;
        dec_o.rs2    = instr_i.r.rs2;
        dec_o.funct3 = instr_i.r.funct3;
        dec_o.alu_op = rv_pkg::ALU_ADD;
        case (instr_i.r.opcode)
            `RV_OP_LUI: begin
                dec_o.imm   = imm_u;
                dec_o.rs1   = '0;      // x0 + imm
                dec_o.b_imm = 1'b1;
                dec_o.wr_rd = 1'b1;
            end
            `RV_OP_AUIPC: begin
                dec_o.imm   = imm_u;
                dec_o.a_pc  = 1'b1;
                dec_o.b_imm = 1'b1;
                dec_o.wr_rd = 1'b1;
            end
            `RV_OP_JAL: begin
                dec_o.imm    = imm_j;
                dec_o.is_jal = 1'b1;
                dec_o.wr_rd  = 1'b1;
            end
            `RV_OP_JALR: begin
                dec_o.imm     = imm_i;
                dec_o.b_imm   = 1'b1;
                dec_o.is_jalr = 1'b1;
                dec_o.wr_rd   = 1'b1;
                dec_o.illegal = instr_i.i.funct3 != 3'b000;
            end
            `RV_OP_BRANCH: begin
                dec_o.imm       = imm_b;
                dec_o.is_branch = 1'b1;
                dec_o.illegal   = instr_i.b.funct3[2:1] == 2'b01;   // 010 and 011 unused
            end
            `RV_OP_LOAD: begin
                dec_o.imm     = imm_i;
                dec_o.b_imm   = 1'b1;
                dec_o.is_load = 1'b1;
                dec_o.wr_rd   = 1'b1;
                dec_o.illegal = instr_i.i.funct3 != 3'b011;   // LD only
            end
            `RV_OP_STORE: begin
                dec_o.imm      = imm_s;
                dec_o.b_imm    = 1'b1;
                dec_o.is_store = 1'b1;
                dec_o.illegal  = instr_i.s.funct3 != 3'b011;  // SD only
            end
            `RV_OP_IMM: begin
                dec_o.imm    = imm_i;
                dec_o.b_imm  = 1'b1;
                dec_o.wr_rd  = 1'b1;
                dec_o.alu_op = base_op;
                // Bit 0 of funct7 is shamt[5] here
                if (instr_i.r.funct3 == 3'b001) begin
                    dec_o.illegal = instr_i.r.funct7[6:1] != 6'b000000;
                end else if (instr_i.r.funct3 == 3'b101) begin
                    if (instr_i.r.funct7[6:1] == 6'b010000) begin
                        dec_o.alu_op = rv_pkg::ALU_SRA;
                    end else begin
                        dec_o.illegal = instr_i.r.funct7[6:1] != 6'b000000;
                    end
                end
            end
            `RV_OP_REG: begin
                dec_o.wr_rd = 1'b1;
                if (instr_i.r.funct7 == 7'b0000000) begin
                    dec_o.alu_op = base_op;
                end else if (instr_i.r.funct7 == 7'b0100000 && instr_i.r.funct3 == 3'b000) begin
                    dec_o.alu_op = rv_pkg::ALU_SUB;
                end else if (instr_i.r.funct7 == 7'b0100000 && instr_i.r.funct3 == 3'b101) begin
                    dec_o.alu_op = rv_pkg::ALU_SRA;
                end else begin
                    dec_o.illegal = 1'b1;
                end
            end
            default: dec_o.illegal = 1'b1;
        endcase

        // Unknown words fall through as a no-op
        if (dec_o.illegal) begin
            dec_o.wr_rd     = 1'b0;
            dec_o.is_load   = 1'b0;
            dec_o.is_store  = 1'b0;
            dec_o.is_jalr   = 1'b0;
            dec_o.is_branch = 1'b0;
        end
    end

endmodule

// ==== logic/rv_fetch_stage.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_fetch_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic [`RV_ILEN-1:0] instr_i,
    input  logic                stall_i,
    input  logic                redirect_i,
    input  logic [`RV_XLEN-1:0] target_pc_i,
    output logic [`RV_XLEN-1:0] pc_o,
    output rv_pkg::rv_instr_u   fetch_word_o,
    output logic [`RV_XLEN-1:0] fetch_pc_o
);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_o         <= `RV_RESET_PC;
            fetch_word_o <= `RV_NOP;
            fetch_pc_o   <= `RV_RESET_PC;
        end else if (redirect_i) begin
            pc_o         <= target_pc_i;
            fetch_word_o <= `RV_NOP;   // Bubble over the wrong-path word
        end else if (!stall_i) begin
            pc_o         <= pc_o + 'd4;
            fetch_word_o <= instr_i;
            fetch_pc_o   <= pc_o;
        end
    end

    // Jumps never come from a memory op, so the two must not coincide
    a_no_redirect_in_stall: assert property (@(posedge clk) disable iff (!reset)
        !(redirect_i && stall_i));

endmodule

// ==== logic/rv_pkg.sv ====
`include "rv_params.svh"

package rv_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } rv_s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } rv_b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_j_fmt_t;

    // One fetched word, six views
    typedef union packed {
        rv_r_fmt_t r;
        rv_i_fmt_t i;
        rv_s_fmt_t s;
        rv_b_fmt_t b;
        rv_u_fmt_t u;
        rv_j_fmt_t j;
    } rv_instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } rv_alu_op_e;

    typedef struct packed {
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [`RV_XLEN-1:0] imm;      // Already sign-extended
        rv_alu_op_e          alu_op;
        logic                b_imm;    // Operand b from immediate
        logic                a_pc;     // Operand a from pc
        logic                wr_rd;
        logic                is_load;
        logic                is_store;
        logic                is_jal;
        logic                is_jalr;
        logic                is_branch;
        logic [2:0]          funct3;
        logic                illegal;
    } rv_decoded_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] wdata;
        logic                we;
    } rv_bus_req_t;

endpackage

// ==== logic/rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Datapath and instruction widths
`define RV_XLEN       64
`define RV_ILEN       32
`define RV_REG_COUNT  32

`define RV_RESET_PC   64'h0000_0000_0000_0000
`define RV_NOP        32'h0000_0013   // addi x0, x0, 0

// Major opcodes
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_IMM     7'b0010011
`define RV_OP_REG     7'b0110011

`endif
